// File: Bender.yml
package:
  name: tcdm_ecc

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/tcdm_ecc_pkg.sv
      - rtl/hsiao_enc.sv
      - rtl/hsiao_dec.sv
      - rtl/tcdm_ecc_enc.sv
      - rtl/tcdm_ecc_bank.sv
      - rtl/tcdm_ecc_subsys.sv

  - target: test
    include_dirs:
      - rtl
    files:
      - test/tb_tcdm_ecc.sv

// File: build.f
+incdir+rtl
rtl/tcdm_ecc_pkg.sv
rtl/hsiao_enc.sv
rtl/hsiao_dec.sv
rtl/tcdm_ecc_enc.sv
rtl/tcdm_ecc_bank.sv
rtl/tcdm_ecc_subsys.sv
test/tb_tcdm_ecc.sv

// File: rtl/hsiao_dec.sv
`timescale 1ns/10ps
`default_nettype none

module hsiao_dec
  import tcdm_ecc_pkg::*;
#(
  parameter int unsigned DataWidth = 32,
  parameter int unsigned ProtWidth = 7
) (
  // only samples the assertion
  input  logic                 clk_i,
  input  logic [DataWidth-1:0] data_i,
  input  logic [ProtWidth-1:0] ecc_i,
  output logic [DataWidth-1:0] data_o,
  output logic                 single_err_o,
  output logic                 multi_err_o
);

  logic [DataWidth-1:0][ProtWidth-1:0] col;
  logic [ProtWidth-1:0]                ecc_calc;
  logic [ProtWidth-1:0]                syndrome;
  logic [DataWidth-1:0]                hit;
  logic                                check_err;

  for (genvar i = 0; i < DataWidth; i++) begin : gen_col
    assign col[i] = ProtWidth'(hsiao_column(ProtWidth, i));
  end

  // recompute check bits from the received data
  always_comb begin
    ecc_calc = '0;
    for (int unsigned i = 0; i < DataWidth; i++) begin
      if (data_i[i]) begin
        ecc_calc = ecc_calc ^ col[i];
      end
    end
  end

  assign syndrome = ecc_calc ^ ecc_i;

  // a syndrome matching a data column points at the flipped bit
  always_comb begin
    hit = '0;
    for (int unsigned i = 0; i < DataWidth; i++) begin
      hit[i] = (syndrome == col[i]);
    end
  end

  // a weight-one syndrome means a flipped check bit
  assign check_err = (syndrome != '0) && ((syndrome & (syndrome - 1'b1)) == '0);

  assign data_o       = data_i ^ hit;
  assign single_err_o = (|hit) || check_err;
  assign multi_err_o  = (syndrome != '0) && !single_err_o;

  // duplicate or zero columns would correct the wrong bit
  a_hit_unique : assert property (@(posedge clk_i)
    (|hit) |-> ($onehot(hit) && (syndrome != '0)));

endmodule

`default_nettype wire

// File: rtl/hsiao_enc.sv
`timescale 1ns/10ps
`default_nettype none

module hsiao_enc
  import tcdm_ecc_pkg::*;
#(
  parameter int unsigned DataWidth = 32,
  parameter int unsigned ProtWidth = 7
) (
  input  logic [DataWidth-1:0] data_i,
  output logic [ProtWidth-1:0] ecc_o
);

  // parity-check columns, fixed at elaboration
  logic [DataWidth-1:0][ProtWidth-1:0] col;

  for (genvar i = 0; i < DataWidth; i++) begin : gen_col
    assign col[i] = ProtWidth'(hsiao_column(ProtWidth, i));
  end

  // each set data bit contributes its column to the check bits
  always_comb begin
    ecc_o = '0;
    for (int unsigned i = 0; i < DataWidth; i++) begin
      if (data_i[i]) begin
        ecc_o = ecc_o ^ col[i];
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/tcdm_ecc_bank.sv
`timescale 1ns/10ps
`default_nettype none

`include "tcdm_ecc_consts.svh"

module tcdm_ecc_bank
  import tcdm_ecc_pkg::*;
(
  input  logic          clk_i,
  input  logic          arst_n_i,
  input  tcdm_ecc_req_t link_req_i,
  output tcdm_ecc_rsp_t link_rsp_o,
  input  fault_t        fault_i,
  output logic [1:0]    meta_err_o
);

  localparam int unsigned NCh   = `TCDM_NCHUNK;
  localparam int unsigned Chunk = `TCDM_CHUNK;
  localparam int unsigned CwW   = `TCDM_DW + NCh * `TCDM_EW_DW;

  logic [CwW-1:0]                  mem_q [`TCDM_DEPTH];
  logic [`TCDM_RQMETAW-1:0]        meta_rx;
  logic [`TCDM_RQMETAW-1:0]        meta_fix;
  logic                            meta_single;
  logic                            meta_multi;
  logic [`TCDM_AW-1:0]             add;
  logic                            wen;
  logic [`TCDM_BW-1:0]             be;
  logic [`TCDM_UW-1:0]             user;
  logic                            gnt;
  logic                            accept;
  logic                            do_access;
  logic                            do_write;
  logic [CwW-1:0]                  old_cw;
  logic [`TCDM_DW-1:0]             old_data;
  logic [NCh-1:0][`TCDM_EW_DW-1:0] old_ecc;
  logic [`TCDM_DW-1:0]             old_fix;
  logic [`TCDM_DW-1:0]             new_data;
  logic [NCh-1:0][`TCDM_EW_DW-1:0] new_ecc;
  logic [`TCDM_EW_RSMETA-1:0]      user_ecc;

  logic                            r_valid_q;
  logic                            r_opc_q;
  logic [`TCDM_DW-1:0]             r_data_q;
  logic [NCh-1:0][`TCDM_EW_DW-1:0] r_ecc_q;
  logic [`TCDM_UW-1:0]             r_user_q;
  logic [`TCDM_EW_RSMETA-1:0]      r_uecc_q;

  // link fault flips metadata bits in transit
  assign meta_rx = {link_req_i.base.add, link_req_i.base.wen,
                    link_req_i.base.be, link_req_i.base.user} ^ fault_i.link_mask;

  hsiao_dec #(
    .DataWidth ( `TCDM_RQMETAW   ),
    .ProtWidth ( `TCDM_EW_RQMETA )
  ) i_meta_dec (
    .clk_i        ( clk_i               ),
    .data_i       ( meta_rx             ),
    .ecc_i        ( link_req_i.meta_ecc ),
    .data_o       ( meta_fix            ),
    .single_err_o ( meta_single         ),
    .multi_err_o  ( meta_multi          )
  );

  assign {add, wen, be, user} = meta_fix;
  assign meta_err_o = {meta_multi, meta_single};

  // array is busy with the fault write
  assign gnt       = !fault_i.mem_en;
  assign accept    = link_req_i.base.req && gnt;
  assign do_access = accept && !meta_multi;
  assign do_write  = do_access && !wen;

  assign old_cw   = mem_q[add];
  assign old_data = old_cw[`TCDM_DW-1:0];
  assign old_ecc  = old_cw[CwW-1:`TCDM_DW];

  // old word is corrected first so a partial write does not bake in a flip
  for (genvar ii = 0; ii < NCh; ii++) begin : gen_chunk
    hsiao_dec #(
      .DataWidth ( Chunk       ),
      .ProtWidth ( `TCDM_EW_DW )
    ) i_old_dec (
      .clk_i        ( clk_i                          ),
      .data_i       ( old_data[ii*Chunk +: Chunk]    ),
      .ecc_i        ( old_ecc[ii]                    ),
      .data_o       ( old_fix[ii*Chunk +: Chunk]     ),
      .single_err_o (                                ),
      .multi_err_o  (                                )
    );

    hsiao_enc #(
      .DataWidth ( Chunk       ),
      .ProtWidth ( `TCDM_EW_DW )
    ) i_new_enc (
      .data_i ( new_data[ii*Chunk +: Chunk] ),
      .ecc_o  ( new_ecc[ii]                 )
    );
  end

  // byte merge
  always_comb begin
    for (int unsigned b = 0; b < `TCDM_BW; b++) begin
      new_data[b*8 +: 8] = be[b] ? link_req_i.base.data[b*8 +: 8] : old_fix[b*8 +: 8];
    end
  end

  hsiao_enc #(
    .DataWidth ( `TCDM_UW        ),
    .ProtWidth ( `TCDM_EW_RSMETA )
  ) i_user_enc (
    .data_i ( user     ),
    .ecc_o  ( user_ecc )
  );

  always_ff @(posedge clk_i) begin
    if (fault_i.mem_en) begin
      mem_q[fault_i.mem_addr] <= mem_q[fault_i.mem_addr] ^ fault_i.mem_mask;
    end else if (do_write) begin
      mem_q[add] <= {new_ecc, new_data};
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      r_valid_q <= 1'b0;
      r_opc_q   <= 1'b0;
      r_data_q  <= '0;
      r_ecc_q   <= '0;
      r_user_q  <= '0;
      r_uecc_q  <= '0;
    end else begin
      r_valid_q <= accept;
      if (accept) begin
        r_opc_q  <= meta_multi;
        r_user_q <= user;
        r_uecc_q <= user_ecc;
        // reads return the stored codeword and every other access returns zero
        if (do_access && wen) begin
          r_data_q <= old_data;
          r_ecc_q  <= old_ecc;
        end else begin
          r_data_q <= '0;
          r_ecc_q  <= '0;
        end
      end
    end
  end

  assign link_rsp_o = '{gnt:        gnt,
                        r_valid:    r_valid_q,
                        r_data:     r_data_q,
                        r_user:     r_user_q,
                        r_opc:      r_opc_q,
                        r_ecc_data: r_ecc_q,
                        r_ecc_user: r_uecc_q};

  // full-word writes store exactly the check bits sent over the link
  a_link_ecc_match : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (do_write && (be == '1)) |-> (new_ecc == link_req_i.data_ecc));

endmodule

`default_nettype wire

// File: rtl/tcdm_ecc_consts.svh
`ifndef TCDM_ECC_CONSTS_SVH
`define TCDM_ECC_CONSTS_SVH

// data path
`define TCDM_DW        64
`define TCDM_CHUNK     32
`define TCDM_NCHUNK    (`TCDM_DW / `TCDM_CHUNK)
`define TCDM_BW        8

// addressing and user tag
`define TCDM_AW        8
`define TCDM_DEPTH     (1 << `TCDM_AW)
`define TCDM_UW        4

// check bit widths, log2(n)+2 per protected field
`define TCDM_EW_DW     7
`define TCDM_RQMETAW   (`TCDM_AW + 1 + `TCDM_BW + `TCDM_UW)
`define TCDM_EW_RQMETA 7
`define TCDM_EW_RSMETA 4

`endif

// File: rtl/tcdm_ecc_enc.sv
`timescale 1ns/10ps
`default_nettype none

`include "tcdm_ecc_consts.svh"

module tcdm_ecc_enc
  import tcdm_ecc_pkg::*;
(
  input  logic          clk_i,
  input  logic          arst_n_i,
  input  tcdm_req_t     core_req_i,
  output tcdm_rsp_t     core_rsp_o,
  output tcdm_ecc_req_t link_req_o,
  input  tcdm_ecc_rsp_t link_rsp_i,
  output ecc_err_t      err_o
);

  localparam int unsigned NCh   = `TCDM_NCHUNK;
  localparam int unsigned Chunk = `TCDM_CHUNK;

  logic [`TCDM_RQMETAW-1:0]           meta;
  logic [NCh-1:0][`TCDM_EW_DW-1:0]    data_ecc;
  logic [`TCDM_EW_RQMETA-1:0]         meta_ecc;
  logic [NCh-1:0][Chunk-1:0]          r_data_dec;
  logic [NCh-1:0]                     r_data_single;
  logic [NCh-1:0]                     r_data_multi;
  logic [`TCDM_UW-1:0]                r_user_dec;
  logic                               r_user_single;
  logic                               r_user_multi;

  // request side
  assign meta = {core_req_i.add, core_req_i.wen, core_req_i.be, core_req_i.user};

  for (genvar ii = 0; ii < NCh; ii++) begin : gen_data_enc
    hsiao_enc #(
      .DataWidth ( Chunk       ),
      .ProtWidth ( `TCDM_EW_DW )
    ) i_data_enc (
      .data_i ( core_req_i.data[ii*Chunk +: Chunk] ),
      .ecc_o  ( data_ecc[ii]                       )
    );
  end

  hsiao_enc #(
    .DataWidth ( `TCDM_RQMETAW   ),
    .ProtWidth ( `TCDM_EW_RQMETA )
  ) i_meta_enc (
    .data_i ( meta     ),
    .ecc_o  ( meta_ecc )
  );

  assign link_req_o = '{base: core_req_i, data_ecc: data_ecc, meta_ecc: meta_ecc};

  // response side
  for (genvar ii = 0; ii < NCh; ii++) begin : gen_data_dec
    hsiao_dec #(
      .DataWidth ( Chunk       ),
      .ProtWidth ( `TCDM_EW_DW )
    ) i_data_dec (
      .clk_i        ( clk_i                                 ),
      .data_i       ( link_rsp_i.r_data[ii*Chunk +: Chunk]  ),
      .ecc_i        ( link_rsp_i.r_ecc_data[ii]             ),
      .data_o       ( r_data_dec[ii]                        ),
      .single_err_o ( r_data_single[ii]                     ),
      .multi_err_o  ( r_data_multi[ii]                      )
    );
  end

  hsiao_dec #(
    .DataWidth ( `TCDM_UW        ),
    .ProtWidth ( `TCDM_EW_RSMETA )
  ) i_user_dec (
    .clk_i        ( clk_i                 ),
    .data_i       ( link_rsp_i.r_user     ),
    .ecc_i        ( link_rsp_i.r_ecc_user ),
    .data_o       ( r_user_dec            ),
    .single_err_o ( r_user_single         ),
    .multi_err_o  ( r_user_multi          )
  );

  assign core_rsp_o = '{gnt:     link_rsp_i.gnt,
                        r_valid: link_rsp_i.r_valid,
                        r_data:  r_data_dec,
                        r_user:  r_user_dec,
                        r_opc:   link_rsp_i.r_opc};

  // flags only mean something alongside a valid response
  assign err_o.data_single = link_rsp_i.r_valid ? r_data_single : '0;
  assign err_o.data_multi  = link_rsp_i.r_valid ? r_data_multi  : '0;
  assign err_o.meta_single = link_rsp_i.r_valid && r_user_single;
  assign err_o.meta_multi  = link_rsp_i.r_valid && r_user_multi;

  // a dropped access comes back as a clean all-zero codeword
  a_drop_clean : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (link_rsp_i.r_valid && link_rsp_i.r_opc) |-> (err_o == '0));

endmodule

`default_nettype wire

// File: rtl/tcdm_ecc_pkg.sv
`default_nettype none

`include "tcdm_ecc_consts.svh"

package tcdm_ecc_pkg;

  typedef struct packed {
    logic                req;
    logic [`TCDM_AW-1:0] add;
    // high for a read
    logic                wen;
    logic [`TCDM_DW-1:0] data;
    logic [`TCDM_BW-1:0] be;
    logic [`TCDM_UW-1:0] user;
  } tcdm_req_t;

  typedef struct packed {
    logic                gnt;
    logic                r_valid;
    logic [`TCDM_DW-1:0] r_data;
    logic [`TCDM_UW-1:0] r_user;
    logic                r_opc;
  } tcdm_rsp_t;

  typedef struct packed {
    tcdm_req_t                                     base;
    logic [`TCDM_NCHUNK-1:0][`TCDM_EW_DW-1:0]      data_ecc;
    logic [`TCDM_EW_RQMETA-1:0]                    meta_ecc;
  } tcdm_ecc_req_t;

  typedef struct packed {
    logic                                      gnt;
    logic                                      r_valid;
    logic [`TCDM_DW-1:0]                       r_data;
    logic [`TCDM_UW-1:0]                       r_user;
    logic                                      r_opc;
    logic [`TCDM_NCHUNK-1:0][`TCDM_EW_DW-1:0]  r_ecc_data;
    logic [`TCDM_EW_RSMETA-1:0]                r_ecc_user;
  } tcdm_ecc_rsp_t;

  typedef struct packed {
    logic [`TCDM_NCHUNK-1:0] data_single;
    logic [`TCDM_NCHUNK-1:0] data_multi;
    logic                    meta_single;
    logic                    meta_multi;
  } ecc_err_t;

  typedef struct packed {
    logic                                               mem_en;
    logic [`TCDM_AW-1:0]                                mem_addr;
    // stored codeword is {chunk check bits, data}
    logic [`TCDM_DW+`TCDM_NCHUNK*`TCDM_EW_DW-1:0]       mem_mask;
    logic [`TCDM_RQMETAW-1:0]                           link_mask;
  } fault_t;

  // idx-th odd-weight column of weight >= 3, in increasing order
  function automatic int unsigned hsiao_column(input int unsigned prot_w,
                                               input int unsigned idx);
    int unsigned found;
    int unsigned weight;
    found = 0;
    for (int unsigned v = 1; v < (1 << prot_w); v++) begin
      weight = 0;
      for (int unsigned b = 0; b < prot_w; b++) begin
        weight = weight + ((v >> b) & 1);
      end
      if (weight >= 3 && weight[0]) begin
        if (found == idx) begin
          return v;
        end
        found = found + 1;
      end
    end
    return 0;
  endfunction

endpackage

`default_nettype wire

// File: rtl/tcdm_ecc_subsys.sv
`timescale 1ns/10ps
`default_nettype none

module tcdm_ecc_subsys
  import tcdm_ecc_pkg::*;
(
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  tcdm_req_t core_req_i,
  output tcdm_rsp_t core_rsp_o,
  output ecc_err_t  err_o,
  input  fault_t    fault_i
);

  tcdm_ecc_req_t link_req;
  tcdm_ecc_rsp_t link_rsp;

  tcdm_ecc_enc i_enc (
    .clk_i      ( clk_i      ),
    .arst_n_i   ( arst_n_i   ),
    .core_req_i ( core_req_i ),
    .core_rsp_o ( core_rsp_o ),
    .link_req_o ( link_req   ),
    .link_rsp_i ( link_rsp   ),
    .err_o      ( err_o      )
  );

  // metadata errors reach the core only as a dropped access
  tcdm_ecc_bank i_bank (
    .clk_i      ( clk_i    ),
    .arst_n_i   ( arst_n_i ),
    .link_req_i ( link_req ),
    .link_rsp_o ( link_rsp ),
    .fault_i    ( fault_i  ),
    .meta_err_o (          )
  );

endmodule

`default_nettype wire

// File: test/tb_tcdm_ecc.sv
`timescale 1ns/10ps
`default_nettype none

`include "tcdm_ecc_consts.svh"

module tb_tcdm_ecc
  import tcdm_ecc_pkg::*;
();

  localparam int Period = 40;
  localparam int NRows  = 20;
  localparam int CwW    = `TCDM_DW + `TCDM_NCHUNK * `TCDM_EW_DW;

  typedef enum logic [1:0] {
    OP_WR,
    OP_RD,
    OP_MEM_FLT,
    OP_LINK_WR
  } op_e;

  typedef struct packed {
    op_e                      op;
    logic [`TCDM_AW-1:0]      addr;
    logic [`TCDM_DW-1:0]      data;
    logic [`TCDM_BW-1:0]      be;
    logic [`TCDM_UW-1:0]      user;
    logic [CwW-1:0]           mem_mask;
    logic [`TCDM_RQMETAW-1:0] link_mask;
    logic [`TCDM_DW-1:0]      exp_data;
    logic                     chk_data;
    logic                     exp_opc;
    ecc_err_t                 exp_err;
  } row_t;

  logic      clk;
  logic      arst_n;
  tcdm_req_t core_req;
  tcdm_rsp_t core_rsp;
  ecc_err_t  err;
  fault_t    fault;

  row_t      rows     [NRows];
  string     row_name [NRows];
  logic [7:0] shadow  [`TCDM_DEPTH][`TCDM_BW];

  tcdm_ecc_subsys dut (
    .clk_i      ( clk      ),
    .arst_n_i   ( arst_n   ),
    .core_req_i ( core_req ),
    .core_rsp_o ( core_rsp ),
    .err_o      ( err      ),
    .fault_i    ( fault    )
  );

  initial clk = 1'b0;
  always #(Period / 2) clk = ~clk;

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic check_equal(input string test, input string what,
                             input logic [127:0] exp, input logic [127:0] act);
    if (exp !== act) begin
      abort_run($sformatf("ERR %s: %s expected %0h actual %0h", test, what, exp, act));
    end
  endtask

  function automatic int count_bits(input logic [127:0] v);
    int n;
    n = 0;
    for (int i = 0; i < 128; i++) begin
      n = n + v[i];
    end
    return n;
  endfunction

  task automatic set_row(input int idx, input string name, input op_e op,
                         input logic [`TCDM_AW-1:0] addr, input logic [`TCDM_DW-1:0] data,
                         input logic [`TCDM_BW-1:0] be, input logic [CwW-1:0] mmask,
                         input logic [`TCDM_RQMETAW-1:0] lmask);
    row_name[idx]       = name;
    rows[idx]           = '0;
    rows[idx].op        = op;
    rows[idx].addr      = addr;
    rows[idx].data      = data;
    rows[idx].be        = be;
    rows[idx].user      = `TCDM_UW'($urandom);
    rows[idx].mem_mask  = mmask;
    rows[idx].link_mask = lmask;
  endtask

  // consecutive addresses from a random base, one word per scenario
  task automatic build_table();
    logic [`TCDM_AW-1:0] base;
    logic [`TCDM_DW-1:0] d [10];
    logic [CwW-1:0]      m;
    int                  i0;
    int                  i1;
    base = `TCDM_AW'($urandom);
    for (int k = 0; k < 10; k++) begin
      d[k] = {$urandom, $urandom};
    end
    set_row(0, "full_wr", OP_WR, base, d[0], 8'hff, '0, '0);
    set_row(1, "full_rd", OP_RD, base, '0, 8'hff, '0, '0);
    set_row(2, "base_wr", OP_WR, base + 8'd1, d[1], 8'hff, '0, '0);
    set_row(3, "byte_wr", OP_WR, base + 8'd1, d[2], 8'h5a, '0, '0);
    set_row(4, "byte_rd", OP_RD, base + 8'd1, '0, 8'hff, '0, '0);
    // single flips, data bit in chunk 0, then chunk 1, then a check bit
    set_row(5, "c0_wr", OP_WR, base + 8'd2, d[3], 8'hff, '0, '0);
    m = '0;
    m[$urandom % 32] = 1'b1;
    set_row(6, "c0_flip1", OP_MEM_FLT, base + 8'd2, '0, 8'hff, m, '0);
    set_row(7, "c1_wr", OP_WR, base + 8'd3, d[4], 8'hff, '0, '0);
    m = '0;
    m[32 + $urandom % 32] = 1'b1;
    set_row(8, "c1_flip1", OP_MEM_FLT, base + 8'd3, '0, 8'hff, m, '0);
    set_row(9, "chk_wr", OP_WR, base + 8'd4, d[5], 8'hff, '0, '0);
    m = '0;
    m[64 + $urandom % 14] = 1'b1;
    set_row(10, "chk_flip1", OP_MEM_FLT, base + 8'd4, '0, 8'hff, m, '0);
    // double flips inside one chunk
    set_row(11, "c0_wr2", OP_WR, base + 8'd5, d[6], 8'hff, '0, '0);
    i0 = $urandom % 32;
    i1 = (i0 + 1 + $urandom % 31) % 32;
    m = '0;
    m[i0] = 1'b1;
    m[i1] = 1'b1;
    set_row(12, "c0_flip2", OP_MEM_FLT, base + 8'd5, '0, 8'hff, m, '0);
    set_row(13, "c1_wr2", OP_WR, base + 8'd6, d[7], 8'hff, '0, '0);
    m = '0;
    m[32 + $urandom % 32] = 1'b1;
    m[71 + $urandom % 7] = 1'b1;
    set_row(14, "c1_flip2", OP_MEM_FLT, base + 8'd6, '0, 8'hff, m, '0);
    // metadata is {add, wen, be, user}, bit 13 is the address lsb
    set_row(15, "lnk_base_wr", OP_WR, base + 8'd7, d[8], 8'hff, '0, '0);
    set_row(16, "lnk_flip1_wr", OP_LINK_WR, base + 8'd7, d[9], 8'hff, '0, 21'h02000);
    set_row(17, "lnk_flip1_rd", OP_RD, base + 8'd7, '0, 8'hff, '0, '0);
    set_row(18, "lnk_flip2_wr", OP_LINK_WR, base + 8'd7, ~d[9], 8'hff, '0, 21'h00030);
    set_row(19, "lnk_flip2_rd", OP_RD, base + 8'd7, '0, 8'hff, '0, '0);
  endtask

  task automatic write_shadow(input logic [`TCDM_AW-1:0] addr,
                              input logic [`TCDM_DW-1:0] data,
                              input logic [`TCDM_BW-1:0] be);
    for (int b = 0; b < `TCDM_BW; b++) begin
      if (be[b]) begin
        shadow[addr][b] = data[b*8 +: 8];
      end
    end
  endtask

  // walk the table in order and work out what each response must be
  task automatic fill_expected();
    logic [`TCDM_DW-1:0]    word;
    logic [`TCDM_CHUNK-1:0] dm;
    logic [`TCDM_EW_DW-1:0] cm;
    ecc_err_t               e;
    int                     n;
    for (int r = 0; r < NRows; r++) begin
      e    = '0;
      word = '0;
      for (int b = 0; b < `TCDM_BW; b++) begin
        word[b*8 +: 8] = shadow[rows[r].addr][b];
      end
      case (rows[r].op)
        OP_WR: begin
          write_shadow(rows[r].addr, rows[r].data, rows[r].be);
        end
        OP_LINK_WR: begin
          // two flipped metadata bits cannot be corrected, access dropped
          if (count_bits(rows[r].link_mask) > 1) begin
            rows[r].exp_opc  = 1'b1;
            rows[r].chk_data = 1'b1;
          end else begin
            write_shadow(rows[r].addr, rows[r].data, rows[r].be);
          end
        end
        OP_RD: begin
          rows[r].exp_data = word;
          rows[r].chk_data = 1'b1;
        end
        default: begin
          for (int k = 0; k < `TCDM_NCHUNK; k++) begin
            dm = rows[r].mem_mask[k*`TCDM_CHUNK +: `TCDM_CHUNK];
            cm = rows[r].mem_mask[`TCDM_DW + k*`TCDM_EW_DW +: `TCDM_EW_DW];
            n  = count_bits(dm) + count_bits(cm);
            if (n == 1) begin
              e.data_single[k] = 1'b1;
            end else if (n == 2) begin
              e.data_multi[k] = 1'b1;
              word[k*`TCDM_CHUNK +: `TCDM_CHUNK] = word[k*`TCDM_CHUNK +: `TCDM_CHUNK] ^ dm;
            end
          end
          rows[r].exp_data = word;
          rows[r].chk_data = 1'b1;
        end
      endcase
      rows[r].exp_err = e;
    end
  endtask

  // called on a falling edge, returns on a falling edge
  task automatic run_row(input int r);
    row_t row;
    logic granted;
    int   stalls;
    row     = rows[r];
    granted = 1'b0;
    stalls  = 0;
    core_req.req  = 1'b1;
    core_req.add  = row.addr;
    core_req.wen  = (row.op == OP_RD) || (row.op == OP_MEM_FLT);
    core_req.data = row.data;
    core_req.be   = row.be;
    core_req.user = row.user;
    fault.link_mask = row.link_mask;
    if (row.op == OP_MEM_FLT) begin
      fault.mem_en   = 1'b1;
      fault.mem_addr = row.addr;
      fault.mem_mask = row.mem_mask;
    end
    while (!granted) begin
      @(posedge clk);
      granted = core_rsp.gnt;
      @(negedge clk);
      check_equal(row_name[r], "r_valid", granted, core_rsp.r_valid);
      if (!granted) begin
        stalls = stalls + 1;
        // the fault write lasts one cycle, the request stays up
        fault.mem_en   = 1'b0;
        fault.mem_mask = '0;
        if (stalls > 3) begin
          abort_run($sformatf("request of row %s was never granted", row_name[r]));
        end
      end
    end
    check_equal(row_name[r], "stall cycles", (row.op == OP_MEM_FLT) ? 1 : 0, stalls);
    check_equal(row_name[r], "r_opc", row.exp_opc, core_rsp.r_opc);
    check_equal(row_name[r], "r_user", row.user, core_rsp.r_user);
    if (row.chk_data) begin
      check_equal(row_name[r], "r_data", row.exp_data, core_rsp.r_data);
    end
    check_equal(row_name[r], "err", row.exp_err, err);
    core_req = '0;
    fault    = '0;
    @(negedge clk);
    check_equal(row_name[r], "r_valid pulse end", 1'b0, core_rsp.r_valid);
  endtask

  // each row needs at most three cycles
  initial begin
    #(NRows * 4 * Period + 10 * Period);
    abort_run("watchdog expired, the simulation hung");
  end

  initial begin
    core_req = '0;
    fault    = '0;
    arst_n   = 1'b0;
    void'($urandom(32'h2069));
    build_table();
    fill_expected();
    repeat (4) @(negedge clk);
    arst_n = 1'b1;
    check_equal("reset", "r_valid", 1'b0, core_rsp.r_valid);
    check_equal("reset", "r_opc", 1'b0, core_rsp.r_opc);
    check_equal("reset", "err", '0, err);
    @(negedge clk);
    for (int r = 0; r < NRows; r++) begin
      run_row(r);
    end
    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire
